//--- include/timebase_settings.svh
`ifndef TIMEBASE_SETTINGS_SVH
`define TIMEBASE_SETTINGS_SVH

// ----------------------------------------------------------------------
// Timebase dimensions
// ----------------------------------------------------------------------

// Width of the free-running system time.
`define TB_SYSTIME_W 64

// Bits of system time carried in one notify record.
`define TB_LATCH_W 56

// A rollover record is sent whenever these low bits are all ones.
`define TB_ROLL_BITS 26

// The LED pattern moves one place whenever these low bits are zero.
`define TB_LED_WRAP_BITS 22

// ----------------------------------------------------------------------
// Data acquisition outlet and board LEDs
// ----------------------------------------------------------------------

// Width of one outlet word.
`define TB_WORD_W 32

// Number of on-board status LEDs.
`define TB_NLEDS 8

`endif

//--- logic/time_pkg.sv
`include "timebase_settings.svh"

package time_pkg;

	// ------------------------------------------------------------------
	// System time
	// ------------------------------------------------------------------

	// One system time value, counted in clock cycles.
	typedef logic [`TB_SYSTIME_W-1:0] systime_t;

	// Host request to overwrite the system time.
	// en is a single-cycle strobe; value is taken in that cycle.
	typedef struct packed {
		systime_t value;
		logic     en;
	} time_set_t;

	// ------------------------------------------------------------------
	// Events from the counter stage
	// ------------------------------------------------------------------

	// hit pulses for one cycle.
	// is_set tells a host set apart from a rollover of the low bits.
	typedef struct packed {
		logic hit;
		logic is_set;
	} time_event_t;

endpackage

//--- logic/daq_pkg.sv
`include "timebase_settings.svh"

package daq_pkg;

	// ------------------------------------------------------------------
	// Outlet words
	// ------------------------------------------------------------------

	// One beat on the data acquisition outlet.
	// last marks the final word of a record and is only valid with valid.
	typedef struct packed {
		logic [`TB_WORD_W-1:0] data;
		logic                  valid;
		logic                  last;
	} daq_word_t;

	// ------------------------------------------------------------------
	// Record types
	// ------------------------------------------------------------------

	// Carried in the top byte of the first word of a record.
	typedef enum logic [7:0] {
		SYSTIME_SET      = 8'd32,
		SYSTIME_ROLLOVER = 8'd33
	} record_kind_e;

	// ------------------------------------------------------------------
	// Notifier FSM
	// ------------------------------------------------------------------

	// IDLE waits for a pending event.
	// WAIT_GRANT holds the outlet request until the arbiter answers.
	// SEND_LOWER puts out the second word of the record.
	typedef enum logic [1:0] {
		IDLE       = 2'd0,
		WAIT_GRANT = 2'd1,
		SEND_LOWER = 2'd2
	} notify_state_e;

endpackage

//--- logic/systime_counter.sv
`timescale 1ns/100ps
`include "timebase_settings.svh"

module systime_counter (
	input  logic                  clk,
	input  logic                  rst,
	input  time_pkg::time_set_t   time_set,
	output time_pkg::systime_t    systime,
	output time_pkg::time_event_t time_event
);

	logic roll_hit;

	// ------------------------------------------------------------------
	// Time counter
	// ------------------------------------------------------------------

	// The host value is loaded as is.
	// Counting resumes from it on the following cycle.
	always_ff @(posedge clk) begin
		if (rst) begin
			systime <= '0;
		end else if (time_set.en) begin
			systime <= time_set.value;
		end else begin
			systime <= systime + 1'b1;
		end
	end

	// ------------------------------------------------------------------
	// Event detection
	// ------------------------------------------------------------------

	// The low bits are all ones in the last cycle before they wrap.
	assign roll_hit = (systime[`TB_ROLL_BITS-1:0] == {`TB_ROLL_BITS{1'b1}});

	// Both sources are merged into one registered strobe.
	// A set in the same cycle as a rollover is reported as a set.
	always_ff @(posedge clk) begin
		if (rst) begin
			time_event <= '0;
		end else begin
			time_event.hit    <= time_set.en | roll_hit;
			time_event.is_set <= time_set.en;
		end
	end

endmodule

//--- logic/systime_notifier.sv
`timescale 1ns/100ps
`include "timebase_settings.svh"

module systime_notifier (
	input  logic                  clk,
	input  logic                  rst,
	input  time_pkg::systime_t    systime,
	input  time_pkg::time_event_t time_event,
	input  logic                  daq_grant,
	output logic                  daq_req,
	output daq_pkg::daq_word_t    daq_out
);

	import daq_pkg::*;

	notify_state_e         state;
	logic                  pending;
	logic                  pending_is_set;
	logic                  send_is_set;
	logic [`TB_LATCH_W-1:0] latched;
	record_kind_e          kind;
	logic                  take;
	logic                  grant_seen;
	logic [`TB_WORD_W-1:0] out_data;
	logic                  out_valid;
	logic                  out_last;

	// The pending event is taken when the FSM is free.
	assign take       = (state == IDLE) && pending;
	assign grant_seen = (state == WAIT_GRANT) && daq_grant;

	assign kind = send_is_set ? SYSTIME_SET : SYSTIME_ROLLOVER;

	// ------------------------------------------------------------------
	// Control
	// ------------------------------------------------------------------

	always_ff @(posedge clk) begin
		if (rst) begin
			state     <= IDLE;
			pending   <= 1'b0;
			daq_req   <= 1'b0;
			out_valid <= 1'b0;
			out_last  <= 1'b0;
		end else begin
			out_valid <= 1'b0;
			out_last  <= 1'b0;

			// A fresh hit overrides the clear, so an event that lands in
			// the cycle the previous one is taken stays pending.
			if (take) begin
				pending <= 1'b0;
			end
			if (time_event.hit) begin
				pending <= 1'b1;
			end

			case (state)
				IDLE: begin
					if (pending) begin
						daq_req <= 1'b1;
						state   <= WAIT_GRANT;
					end
				end
				WAIT_GRANT: begin
					if (daq_grant) begin
						daq_req   <= 1'b0;
						out_valid <= 1'b1;
						state     <= SEND_LOWER;
					end
				end
				SEND_LOWER: begin
					out_valid <= 1'b1;
					out_last  <= 1'b1;
					state     <= IDLE;
				end
				default: begin
					state <= IDLE;
				end
			endcase
		end
	end

	// ------------------------------------------------------------------
	// Record payload
	// ------------------------------------------------------------------

	always_ff @(posedge clk) begin
		if (time_event.hit) begin
			pending_is_set <= time_event.is_set;
		end
		// Time is frozen when the record leaves IDLE, not when it is sent.
		if (take) begin
			send_is_set <= pending_is_set;
			latched     <= systime[`TB_LATCH_W-1:0];
		end
		if (grant_seen) begin
			out_data <= {kind, latched[`TB_LATCH_W-1:`TB_WORD_W]};
		end else if (state == SEND_LOWER) begin
			out_data <= latched[`TB_WORD_W-1:0];
		end
	end

	assign daq_out = '{data: out_data, valid: out_valid, last: out_last};

endmodule

//--- logic/led_chaser.sv
`timescale 1ns/100ps
`include "timebase_settings.svh"

module led_chaser (
	input  logic                  clk,
	input  logic                  rst,
	input  time_pkg::systime_t    systime,
	output logic [`TB_NLEDS-1:0]  leds
);

	logic wrap;

	// Low time bits at zero mark one step of the chaser.
	assign wrap = (systime[`TB_LED_WRAP_BITS-1:0] == '0);

	// ------------------------------------------------------------------
	// One-hot pattern, rotated left
	// ------------------------------------------------------------------

	always_ff @(posedge clk) begin
		if (rst) begin
			leds <= {{(`TB_NLEDS-1){1'b0}}, 1'b1};
		end else if (wrap) begin
			leds <= {leds[`TB_NLEDS-2:0], leds[`TB_NLEDS-1]};
		end
	end

endmodule

//--- logic/timebase_top.sv
`timescale 1ns/100ps
`include "timebase_settings.svh"

module timebase_top (
	input  logic                  clk,
	input  logic                  rst,
	input  time_pkg::time_set_t   time_set,
	input  logic                  daq_grant,
	output time_pkg::systime_t    systime,
	output logic                  daq_req,
	output daq_pkg::daq_word_t    daq_out,
	output logic [`TB_NLEDS-1:0]  leds
);

	import time_pkg::*;

	time_event_t time_event;

	// ------------------------------------------------------------------
	// Stage one: system time
	// ------------------------------------------------------------------

	systime_counter u_systime_counter (
		.clk        (clk),
		.rst        (rst),
		.time_set   (time_set),
		.systime    (systime),
		.time_event (time_event)
	);

	// Status LEDs run straight off the time counter
	led_chaser u_led_chaser (
		.clk     (clk),
		.rst     (rst),
		.systime (systime),
		.leds    (leds)
	);

	// ------------------------------------------------------------------
	// Stage two: notify records to the outlet
	// ------------------------------------------------------------------

	systime_notifier u_systime_notifier (
		.clk        (clk),
		.rst        (rst),
		.systime    (systime),
		.time_event (time_event),
		.daq_grant  (daq_grant),
		.daq_req    (daq_req),
		.daq_out    (daq_out)
	);

endmodule

//--- test/timebase_assert.sv
`timescale 1ns/100ps
`include "timebase_settings.svh"

module timebase_assert (
	input logic                  clk,
	input logic                  rst,
	input time_pkg::time_set_t   time_set,
	input logic                  daq_grant,
	input time_pkg::systime_t    systime,
	input logic                  daq_req,
	input daq_pkg::daq_word_t    daq_out,
	input logic [`TB_NLEDS-1:0]  leds
);

	import time_pkg::*;
	import daq_pkg::*;

	localparam systime_t TIME_STEP = 1;
	localparam logic [`TB_NLEDS-1:0] LED_RESET = 1;

	bit                     failed = 1'b0;
	logic                   past_valid;
	logic                   prev_rst;
	systime_t               prev_systime;
	time_set_t              prev_set;
	logic                   prev_req;
	logic                   prev_grant;
	logic [`TB_NLEDS-1:0]   prev_leds;
	logic                   first_beat;
	logic                   second_beat;
	record_kind_e           last_kind;
	record_kind_e           rec_kind;
	logic [`TB_LATCH_W-1:0] rec_time;
	systime_t               count_expect;
	logic [`TB_WORD_W-1:0]  upper_expect;
	logic [`TB_WORD_W-1:0]  lower_expect;
	logic [`TB_NLEDS-1:0]   leds_expect;

	// ----------------------------------------------------------------------
	// Reference history
	// ----------------------------------------------------------------------

	always_ff @(posedge clk) begin
		prev_rst     <= rst;
		prev_systime <= systime;
		prev_set     <= time_set;
		prev_req     <= daq_req;
		prev_grant   <= daq_grant;
		prev_leds    <= leds;
		if (rst) begin
			past_valid  <= 1'b0;
			second_beat <= 1'b0;
		end else begin
			past_valid  <= 1'b1;
			second_beat <= first_beat;
		end
	end

	// The newest event decides the type of the next record.
	// A record carries the time of the cycle before daq_req rose.
	always_ff @(posedge clk) begin
		if (time_set.en) begin
			last_kind <= SYSTIME_SET;
		end else if (systime[`TB_ROLL_BITS-1:0] == '1) begin
			last_kind <= SYSTIME_ROLLOVER;
		end
		if (daq_req && !prev_req) begin
			rec_kind <= last_kind;
			rec_time <= prev_systime[`TB_LATCH_W-1:0];
		end
	end

	assign first_beat   = past_valid && prev_req && prev_grant;
	assign count_expect = prev_systime + TIME_STEP;
	assign upper_expect = {rec_kind, rec_time[`TB_LATCH_W-1:`TB_WORD_W]};
	assign lower_expect = rec_time[`TB_WORD_W-1:0];
	assign leds_expect  = (prev_systime[`TB_LED_WRAP_BITS-1:0] == '0) ?
		{prev_leds[`TB_NLEDS-2:0], prev_leds[`TB_NLEDS-1]} : prev_leds;

	// ----------------------------------------------------------------------
	// Checks
	// ----------------------------------------------------------------------

	a_reset_state: assert property (@(posedge clk) prev_rst |-> systime == '0 &&
		leds == LED_RESET && !daq_req && !daq_out.valid && !daq_out.last)
		else begin
			$error("CHECK FAILED after reset systime %h leds %h daq_req %h valid %h last %h",
				$sampled(systime), $sampled(leds), $sampled(daq_req),
				$sampled(daq_out.valid), $sampled(daq_out.last));
			failed = 1'b1;
		end

	a_count: assert property (@(posedge clk) disable iff (rst)
		past_valid && !prev_set.en |-> systime == count_expect)
		else begin
			$error("CHECK FAILED systime got %h expected %h",
				$sampled(systime), $sampled(count_expect));
			failed = 1'b1;
		end

	a_set_load: assert property (@(posedge clk) disable iff (rst)
		past_valid && prev_set.en |-> systime == prev_set.value)
		else begin
			$error("CHECK FAILED systime got %h expected %h",
				$sampled(systime), $sampled(prev_set.value));
			failed = 1'b1;
		end

	a_back_pressure: assert property (@(posedge clk) disable iff (rst)
		past_valid && prev_req && !prev_grant |-> daq_req && !daq_out.valid)
		else begin
			$error("CHECK FAILED daq_req got %h expected 1 and daq_out.valid got %h expected 0",
				$sampled(daq_req), $sampled(daq_out.valid));
			failed = 1'b1;
		end

	a_first_beat: assert property (@(posedge clk) disable iff (rst)
		first_beat |-> !daq_req && daq_out.valid && !daq_out.last &&
		daq_out.data == upper_expect)
		else begin
			$error("CHECK FAILED first beat daq_req %h valid %h last %h data %h expected %h",
				$sampled(daq_req), $sampled(daq_out.valid), $sampled(daq_out.last),
				$sampled(daq_out.data), $sampled(upper_expect));
			failed = 1'b1;
		end

	a_second_beat: assert property (@(posedge clk) disable iff (rst)
		second_beat |-> daq_out.valid && daq_out.last && daq_out.data == lower_expect)
		else begin
			$error("CHECK FAILED second beat valid %h last %h data %h expected %h",
				$sampled(daq_out.valid), $sampled(daq_out.last),
				$sampled(daq_out.data), $sampled(lower_expect));
			failed = 1'b1;
		end

	a_last_with_valid: assert property (@(posedge clk) disable iff (rst)
		daq_out.last |-> daq_out.valid)
		else begin
			$error("CHECK FAILED daq_out.valid got %h expected 1 with last",
				$sampled(daq_out.valid));
			failed = 1'b1;
		end

	// Valid only shows up in the two beats that follow a grant.
	a_valid_window: assert property (@(posedge clk) disable iff (rst)
		daq_out.valid |-> first_beat || second_beat)
		else begin
			$error("Beat on daq_out appeared without a grant before it.");
			failed = 1'b1;
		end

	a_led_step: assert property (@(posedge clk) disable iff (rst)
		past_valid |-> leds == leds_expect)
		else begin
			$error("CHECK FAILED leds got %h expected %h",
				$sampled(leds), $sampled(leds_expect));
			failed = 1'b1;
		end

endmodule

//--- test/timebase_tb.sv
`timescale 1ns/100ps
`include "timebase_settings.svh"

module timebase_tb;

	import time_pkg::*;
	import daq_pkg::*;

	localparam int WAIT_LIMIT = 64;

	logic                 clk;
	logic                 rst;
	time_set_t            time_set;
	logic                 daq_grant;
	systime_t             systime;
	logic                 daq_req;
	daq_word_t            daq_out;
	logic [`TB_NLEDS-1:0] leds;
	integer               seed = 32'ha8f9;

	timebase_top u_timebase_top (
		.clk       (clk),
		.rst       (rst),
		.time_set  (time_set),
		.daq_grant (daq_grant),
		.systime   (systime),
		.daq_req   (daq_req),
		.daq_out   (daq_out),
		.leds      (leds)
	);

	bind timebase_top timebase_assert u_timebase_assert (
		.clk       (clk),
		.rst       (rst),
		.time_set  (time_set),
		.daq_grant (daq_grant),
		.systime   (systime),
		.daq_req   (daq_req),
		.daq_out   (daq_out),
		.leds      (leds)
	);

	initial clk = 1'b0;
	always #2 clk = ~clk;

	// ----------------------------------------------------------------------
	// Helpers
	// ----------------------------------------------------------------------

	task automatic abort_run(input string what);
		$display("%s", what);
		$display("TEST RESULT: FAIL");
		$fatal(1, "Simulation stopped.");
	endtask

	// Loads a new time with a one-cycle strobe.
	task automatic set_time(input systime_t new_time);
		@(posedge clk);
		time_set <= '{value: new_time, en: 1'b1};
		@(posedge clk);
		time_set.en <= 1'b0;
	endtask

	// Plays the arbiter for one record with a random grant delay.
	task automatic serve_record();
		int cycles;
		int delay;
		cycles = 0;
		do begin
			@(negedge clk);
			cycles++;
			if (cycles > WAIT_LIMIT) begin
				abort_run("Timed out waiting for daq_req to rise.");
			end
		end while (!daq_req);
		delay = $unsigned($random(seed)) % 16;
		repeat (delay) @(posedge clk);
		@(posedge clk);
		daq_grant <= 1'b1;
		cycles = 0;
		do begin
			@(negedge clk);
			cycles++;
			if (cycles > WAIT_LIMIT) begin
				abort_run("Timed out waiting for daq_req to fall after the grant.");
			end
		end while (daq_req);
		@(posedge clk);
		daq_grant <= 1'b0;
		cycles = 0;
		do begin
			@(negedge clk);
			cycles++;
			if (cycles > WAIT_LIMIT) begin
				abort_run("Timed out waiting for the last beat of a record.");
			end
		end while (!(daq_out.valid && daq_out.last));
	endtask

	always @(negedge clk) begin
		if (u_timebase_top.u_timebase_assert.failed) begin
			abort_run("An assertion on the timebase failed.");
		end
	end

	// ----------------------------------------------------------------------
	// Stimulus
	// ----------------------------------------------------------------------

	initial begin
		rst       = 1'b1;
		time_set  = '0;
		daq_grant = 1'b0;
		repeat (3) @(posedge clk);
		rst <= 1'b0;
		repeat (8) @(posedge clk);

		// Far from both the rollover and the LED wrap.
		set_time(64'h0012_3456_0012_3456);
		serve_record();

		// The set record comes first, the rollover record after it.
		set_time({38'h1_5c3e_9b17, 26'h3fffff0});
		serve_record();
		serve_record();

		// Low 22 bits six counts short of zero.
		set_time(64'h0000_0abc_d57f_fffa);
		serve_record();
		repeat (20) @(posedge clk);

		@(negedge clk);
		if (u_timebase_top.u_timebase_assert.failed) begin
			abort_run("An assertion on the timebase failed.");
		end else begin
			$display("TEST RESULT: PASS");
			$finish;
		end
	end

endmodule

//--- compile.f
+incdir+include
logic/time_pkg.sv
logic/daq_pkg.sv
logic/systime_counter.sv
logic/systime_notifier.sv
logic/led_chaser.sv
logic/timebase_top.sv
test/timebase_assert.sv
test/timebase_tb.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert --timescale 1ns/100ps -j 0
TOP       ?= timebase_tb
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
RUN_FLAGS ?= +verilator+error+limit+100
PASS_MSG  := TEST RESULT: PASS

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, look for the pass message"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP) $(RUN_FLAGS) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
